//--- design/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// instruction, data and pc word width
`define DATA_WIDTH 32

// general register file size
`define GPR_NUM 32

// register address width, derived from the register count
`define REG_ADDR_WIDTH ($clog2(`GPR_NUM))

// slots per fetch packet, one decode lane each
// 2 or 4 are the intended values
`define DECODE_WIDTH 2

// width of the valid result count, 0 up to DECODE_WIDTH
`define DEC_COUNT_WIDTH ($clog2(`DECODE_WIDTH + 1))

`endif

//--- design/la_isa_pkg.sv
package la_isa_pkg;

    // 2RI14 major opcodes, instr[31:24]
    typedef enum logic [7:0] {
        LL_W = 8'h20,
        SC_W = 8'h21
    } opc8_e;

    // 2RI12 opcodes, instr[31:22]
    typedef enum logic [9:0] {
        SLTI   = 10'h008,
        ADDI_W = 10'h00A,
        ANDI   = 10'h00D,
        ORI    = 10'h00E,
        LD_W   = 10'h0A2,
        ST_W   = 10'h0A6
    } opc10_e;

    // operation handed to execute
    typedef enum logic [7:0] {
        ALU_NOP  = 8'h00,
        ALU_ADD  = 8'h01,
        ALU_SLT  = 8'h02,
        ALU_AND  = 8'h03,
        ALU_OR   = 8'h04,
        ALU_LL   = 8'h05,
        ALU_SC   = 8'h06,
        ALU_LD_W = 8'h07,
        ALU_ST_W = 8'h08
    } aluop_e;

    // which result path the instruction writes back through
    typedef enum logic [2:0] {
        RES_NOP        = 3'd0,
        RES_ARITH      = 3'd1,
        RES_LOGIC      = 3'd2,
        RES_MOVE       = 3'd3,
        RES_LOAD_STORE = 3'd4
    } alusel_e;

endpackage

//--- design/core_types_pkg.sv
`include "decode_cfg.svh"

package core_types_pkg;

    // one fetched slot, pc already per slot
    typedef struct packed {
        logic                   valid;
        logic [`DATA_WIDTH-1:0] pc;
        logic [`DATA_WIDTH-1:0] instr;
    } instr_buffer_info_t;

    // decoded instruction as seen by the rest of the pipeline
    typedef struct packed {
        logic                         valid;
        // valid slot whose word no decoder accepted
        logic                         illegal;
        logic [`DATA_WIDTH-1:0]       pc;
        // {rk-slot, rj-slot}
        logic [1:0]                   reg_read_valid;
        logic [2*`REG_ADDR_WIDTH-1:0] reg_read_addr;
        // immediate replaces the second operand
        logic                         use_imm;
        logic [`DATA_WIDTH-1:0]       imm;
        logic                         reg_write_valid;
        logic [`REG_ADDR_WIDTH-1:0]   reg_write_addr;
        la_isa_pkg::aluop_e           aluop;
        la_isa_pkg::alusel_e          alusel;
    } decode_result_t;

endpackage

//--- design/decoder_2ri14.sv
`include "decode_cfg.svh"

// 2RI14 layout {opcode[8], imm14, rj, rd}
// only the LL.W / SC.W pair is decoded here
module decoder_2ri14 (
    input  core_types_pkg::instr_buffer_info_t instr_info_i,
    output logic                               hit_o,
    output core_types_pkg::decode_result_t     result_o
);

    logic [`DATA_WIDTH-1:0]     instr;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rj;
    logic [13:0]                imm14;
    logic [`DATA_WIDTH-1:0]     imm_shifted;

    assign instr = instr_info_i.instr;
    assign rd    = instr[4:0];
    assign rj    = instr[9:5];
    assign imm14 = instr[23:10];

    // word offset, sign extended then scaled to bytes
    assign imm_shifted = {{(`DATA_WIDTH - 16){imm14[13]}}, imm14, 2'b00};

    always_comb begin
        hit_o    = 1'b0;
        result_o = '0;
        result_o.aluop  = la_isa_pkg::ALU_NOP;
        result_o.alusel = la_isa_pkg::RES_NOP;
        case (instr[31:24])
            la_isa_pkg::LL_W: begin
                hit_o = 1'b1;
                // base register only
                result_o.reg_read_valid  = 2'b01;
                result_o.reg_read_addr   = {{`REG_ADDR_WIDTH{1'b0}}, rj};
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr  = rd;
                result_o.use_imm         = 1'b0;
                result_o.imm             = imm_shifted;
                result_o.aluop           = la_isa_pkg::ALU_LL;
                result_o.alusel          = la_isa_pkg::RES_MOVE;
            end
            la_isa_pkg::SC_W: begin
                hit_o = 1'b1;
                // rd is both store data and success flag
                result_o.reg_read_valid  = 2'b11;
                result_o.reg_read_addr   = {rd, rj};
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr  = rd;
                result_o.use_imm         = 1'b0;
                result_o.imm             = imm_shifted;
                result_o.aluop           = la_isa_pkg::ALU_SC;
                result_o.alusel          = la_isa_pkg::RES_MOVE;
            end
            default: begin
                hit_o    = 1'b0;
                result_o = '0;
            end
        endcase
    end

endmodule

//--- design/decoder_2ri12.sv
`include "decode_cfg.svh"

// 2RI12 layout {opcode[10], imm12, rj, rd}
module decoder_2ri12 (
    input  core_types_pkg::instr_buffer_info_t instr_info_i,
    output logic                               hit_o,
    output core_types_pkg::decode_result_t     result_o
);

    logic [`DATA_WIDTH-1:0]     instr;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rj;
    logic [11:0]                imm12;
    logic [`DATA_WIDTH-1:0]     imm_sext;
    logic [`DATA_WIDTH-1:0]     imm_zext;

    assign instr    = instr_info_i.instr;
    assign rd       = instr[4:0];
    assign rj       = instr[9:5];
    assign imm12    = instr[21:10];
    assign imm_sext = {{(`DATA_WIDTH - 12){imm12[11]}}, imm12};
    // logic ops take the immediate unsigned
    assign imm_zext = {{(`DATA_WIDTH - 12){1'b0}}, imm12};

    always_comb begin
        hit_o    = 1'b1;
        result_o = '0;
        // common pattern: read rj, write rd, immediate operand
        result_o.reg_read_valid  = 2'b01;
        result_o.reg_read_addr   = {{`REG_ADDR_WIDTH{1'b0}}, rj};
        result_o.reg_write_valid = 1'b1;
        result_o.reg_write_addr  = rd;
        result_o.use_imm         = 1'b1;
        result_o.imm             = imm_sext;
        result_o.aluop           = la_isa_pkg::ALU_NOP;
        result_o.alusel          = la_isa_pkg::RES_NOP;
        case (instr[31:22])
            la_isa_pkg::ADDI_W: begin
                result_o.aluop  = la_isa_pkg::ALU_ADD;
                result_o.alusel = la_isa_pkg::RES_ARITH;
            end
            la_isa_pkg::SLTI: begin
                result_o.aluop  = la_isa_pkg::ALU_SLT;
                result_o.alusel = la_isa_pkg::RES_ARITH;
            end
            la_isa_pkg::ANDI: begin
                result_o.imm    = imm_zext;
                result_o.aluop  = la_isa_pkg::ALU_AND;
                result_o.alusel = la_isa_pkg::RES_LOGIC;
            end
            la_isa_pkg::ORI: begin
                result_o.imm    = imm_zext;
                result_o.aluop  = la_isa_pkg::ALU_OR;
                result_o.alusel = la_isa_pkg::RES_LOGIC;
            end
            la_isa_pkg::LD_W: begin
                result_o.aluop  = la_isa_pkg::ALU_LD_W;
                result_o.alusel = la_isa_pkg::RES_LOAD_STORE;
            end
            la_isa_pkg::ST_W: begin
                // store data comes from rd, nothing written back
                result_o.reg_read_valid  = 2'b11;
                result_o.reg_read_addr   = {rd, rj};
                result_o.reg_write_valid = 1'b0;
                result_o.reg_write_addr  = '0;
                result_o.aluop           = la_isa_pkg::ALU_ST_W;
                result_o.alusel          = la_isa_pkg::RES_LOAD_STORE;
            end
            default: begin
                hit_o    = 1'b0;
                result_o = '0;
            end
        endcase
    end

endmodule

//--- design/decode_lane.sv
`include "decode_cfg.svh"

// one decode lane, purely combinational
module decode_lane (
    input  core_types_pkg::instr_buffer_info_t instr_info_i,
    output core_types_pkg::decode_result_t     result_o
);

    logic                           hit_2ri14;
    logic                           hit_2ri12;
    core_types_pkg::decode_result_t result_2ri14;
    core_types_pkg::decode_result_t result_2ri12;

    decoder_2ri14 u_dec_2ri14 (
        .instr_info_i (instr_info_i),
        .hit_o        (hit_2ri14),
        .result_o     (result_2ri14)
    );

    decoder_2ri12 u_dec_2ri12 (
        .instr_info_i (instr_info_i),
        .hit_o        (hit_2ri12),
        .result_o     (result_2ri12)
    );

    // opcode spaces are disjoint, so at most one decoder hits
    always_comb begin
        if (hit_2ri14) begin
            result_o = result_2ri14;
        end else if (hit_2ri12) begin
            result_o = result_2ri12;
        end else begin
            // unknown word, no register traffic
            result_o                 = '0;
            result_o.illegal         = instr_info_i.valid;
            result_o.reg_read_valid  = 2'b00;
            result_o.reg_write_valid = 1'b0;
            result_o.aluop           = la_isa_pkg::ALU_NOP;
            result_o.alusel          = la_isa_pkg::RES_NOP;
        end
        result_o.valid = instr_info_i.valid;
        result_o.pc    = instr_info_i.pc;
    end

endmodule

//--- design/instr_dispatcher.sv
`include "decode_cfg.svh"

// first register stage of decode
module instr_dispatcher (
    input  logic                                                 clk_i,
    input  logic                                                 arst_n_i,
    input  logic [`DECODE_WIDTH-1:0]                             fetch_valid_i,
    input  logic [`DATA_WIDTH-1:0]                               fetch_pc_i,
    input  logic [`DECODE_WIDTH-1:0][`DATA_WIDTH-1:0]            fetch_instr_i,
    output core_types_pkg::instr_buffer_info_t [`DECODE_WIDTH-1:0] slot_o
);

    logic [`DECODE_WIDTH-1:0]                  valid_q;
    logic [`DECODE_WIDTH-1:0][`DATA_WIDTH-1:0] pc_q;
    logic [`DECODE_WIDTH-1:0][`DATA_WIDTH-1:0] instr_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= fetch_valid_i;
        end
    end

    // slot k sits k words after the packet base
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < `DECODE_WIDTH; k++) begin
            pc_q[k]    <= fetch_pc_i + `DATA_WIDTH'(4 * k);
            instr_q[k] <= fetch_instr_i[k];
        end
    end

    always_comb begin
        for (int k = 0; k < `DECODE_WIDTH; k++) begin
            slot_o[k].valid = valid_q[k];
            slot_o[k].pc    = pc_q[k];
            slot_o[k].instr = instr_q[k];
        end
    end

endmodule

//--- design/decode_collector.sv
`include "decode_cfg.svh"

// compacts valid lane results toward slot 0, program order kept
module decode_collector (
    input  logic                                                 clk_i,
    input  logic                                                 arst_n_i,
    input  core_types_pkg::decode_result_t [`DECODE_WIDTH-1:0]   lane_result_i,
    output core_types_pkg::decode_result_t [`DECODE_WIDTH-1:0]   dec_result_o,
    output logic [`DEC_COUNT_WIDTH-1:0]                          dec_count_o
);

    core_types_pkg::decode_result_t [`DECODE_WIDTH-1:0] packed_d;
    core_types_pkg::decode_result_t [`DECODE_WIDTH-1:0] result_q;
    logic [`DEC_COUNT_WIDTH-1:0]                        count_d;
    logic [`DECODE_WIDTH-1:0]                           valid_q;
    logic [`DEC_COUNT_WIDTH-1:0]                        count_q;

    // count_d doubles as the next free output slot
    always_comb begin
        packed_d = '0;
        count_d  = '0;
        for (int k = 0; k < `DECODE_WIDTH; k++) begin
            if (lane_result_i[k].valid) begin
                packed_d[count_d] = lane_result_i[k];
                count_d           = count_d + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            count_q <= '0;
        end else begin
            for (int k = 0; k < `DECODE_WIDTH; k++) begin
                valid_q[k] <= packed_d[k].valid;
            end
            count_q <= count_d;
        end
    end

    always_ff @(posedge clk_i) begin
        result_q <= packed_d;
    end

    // valid comes from the reset flops, payload from the plain ones
    always_comb begin
        for (int k = 0; k < `DECODE_WIDTH; k++) begin
            dec_result_o[k]       = result_q[k];
            dec_result_o[k].valid = valid_q[k];
        end
    end

    assign dec_count_o = count_q;

endmodule

//--- design/decode_stage.sv
`include "decode_cfg.svh"

// decode stage top, two cycles from fetch packet to results
module decode_stage (
    input  logic                                                 clk_i,
    input  logic                                                 arst_n_i,
    input  logic [`DECODE_WIDTH-1:0]                             fetch_valid_i,
    input  logic [`DATA_WIDTH-1:0]                               fetch_pc_i,
    input  logic [`DECODE_WIDTH-1:0][`DATA_WIDTH-1:0]            fetch_instr_i,
    output core_types_pkg::decode_result_t [`DECODE_WIDTH-1:0]   dec_result_o,
    output logic [`DEC_COUNT_WIDTH-1:0]                          dec_count_o
);

    core_types_pkg::instr_buffer_info_t [`DECODE_WIDTH-1:0] slot;
    core_types_pkg::decode_result_t [`DECODE_WIDTH-1:0]     lane_result;

    instr_dispatcher u_dispatcher (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_instr_i (fetch_instr_i),
        .slot_o        (slot)
    );

    for (genvar g = 0; g < `DECODE_WIDTH; g++) begin : g_lane
        decode_lane u_lane (
            .instr_info_i (slot[g]),
            .result_o     (lane_result[g])
        );
    end

    decode_collector u_collector (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .lane_result_i (lane_result),
        .dec_result_o  (dec_result_o),
        .dec_count_o   (dec_count_o)
    );

endmodule

//--- sim/decode_asserts.sv
`include "decode_cfg.svh"

// collector output invariants, bound into decode_collector
module decode_asserts (
    input logic                                               clk_i,
    input logic                                               arst_n_i,
    input core_types_pkg::decode_result_t [`DECODE_WIDTH-1:0] dec_result_i,
    input logic [`DEC_COUNT_WIDTH-1:0]                        dec_count_i
);

    logic [`DECODE_WIDTH-1:0] valid_vec;
    logic                     slot_gap;
    logic                     illegal_write;

    // number of assertion failures so far
    int fail_count = 0;

    always_comb begin
        illegal_write = 1'b0;
        for (int k = 0; k < `DECODE_WIDTH; k++) begin
            valid_vec[k]  = dec_result_i[k].valid;
            illegal_write = illegal_write
                | (dec_result_i[k].illegal & dec_result_i[k].reg_write_valid);
        end
    end

    // a valid slot above an invalid one means compaction left a hole
    always_comb begin
        slot_gap = 1'b0;
        for (int k = 1; k < `DECODE_WIDTH; k++) begin
            slot_gap = slot_gap | (dec_result_i[k].valid & ~dec_result_i[k-1].valid);
        end
    end

    a_no_gap: assert property (@(posedge clk_i) disable iff (!arst_n_i) !slot_gap)
        else begin
            fail_count++;
            $error("valid result sits above an invalid lower slot");
        end

    a_illegal_no_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !illegal_write)
        else begin
            fail_count++;
            $error("illegal result carries a register write");
        end

    a_count_matches: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        dec_count_i == $countones(valid_vec))
        else begin
            fail_count++;
            $error("dec_count_o differs from the number of valid slots");
        end

endmodule

bind decode_collector decode_asserts u_asserts (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .dec_result_i (dec_result_o),
    .dec_count_i  (dec_count_o)
);

//--- sim/tb_decode_stage.sv
`include "decode_cfg.svh"

module tb_decode_stage;

    localparam int RANDOM_PACKETS = 300;
    // reset, directed packets with flushes, random packets, margin
    localparam int TIMEOUT_CYCLES = 16 + 40 + RANDOM_PACKETS + 100;

    // one expected collector output
    typedef struct packed {
        core_types_pkg::decode_result_t [`DECODE_WIDTH-1:0] res;
        logic [`DEC_COUNT_WIDTH-1:0]                        count;
    } expect_t;

    logic                                               clk;
    logic                                               arst_n;
    logic [`DECODE_WIDTH-1:0]                           fetch_valid;
    logic [`DATA_WIDTH-1:0]                             fetch_pc;
    logic [`DECODE_WIDTH-1:0][`DATA_WIDTH-1:0]          fetch_instr;
    core_types_pkg::decode_result_t [`DECODE_WIDTH-1:0] dec_result;
    logic [`DEC_COUNT_WIDTH-1:0]                        dec_count;

    expect_t exp_q[$];
    integer  seed;
    int      cycle_count = 0;

    decode_stage dut0 (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .fetch_valid_i (fetch_valid),
        .fetch_pc_i    (fetch_pc),
        .fetch_instr_i (fetch_instr),
        .dec_result_o  (dec_result),
        .dec_count_o   (dec_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    always @(negedge clk) begin
        if (dut0.u_collector.u_asserts.fail_count != 0) begin
            abort_run("Bound assertions on the collector outputs reported a failure");
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail at time %0t: %s is %0h, expected %0h",
                                $time, name, actual, expected));
        end
    endtask

    function automatic logic [31:0] enc_2ri14(input logic [7:0] opc, input logic [13:0] imm,
                                              input logic [4:0] rj, input logic [4:0] rd);
        return {opc, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(input logic [9:0] opc, input logic [11:0] imm,
                                              input logic [4:0] rj, input logic [4:0] rd);
        return {opc, imm, rj, rd};
    endfunction

    // reference decode of one valid slot
    function automatic core_types_pkg::decode_result_t ref_decode(input logic [31:0] pc,
                                                                  input logic [31:0] word);
        core_types_pkg::decode_result_t r;
        logic [4:0]                     rd;
        logic [4:0]                     rj;
        r       = '0;
        rd      = word[4:0];
        rj      = word[9:5];
        r.valid = 1'b1;
        r.pc    = pc;
        if (word[31:24] == 8'h20 || word[31:24] == 8'h21) begin
            r.imm             = {{16{word[23]}}, word[23:10], 2'b00};
            r.reg_write_valid = 1'b1;
            r.reg_write_addr  = rd;
            r.alusel          = la_isa_pkg::RES_MOVE;
            if (word[24]) begin
                r.reg_read_valid = 2'b11;
                r.reg_read_addr  = {rd, rj};
                r.aluop          = la_isa_pkg::ALU_SC;
            end else begin
                r.reg_read_valid = 2'b01;
                r.reg_read_addr  = {5'd0, rj};
                r.aluop          = la_isa_pkg::ALU_LL;
            end
        end else begin
            r.use_imm         = 1'b1;
            r.imm             = {{20{word[21]}}, word[21:10]};
            r.reg_read_valid  = 2'b01;
            r.reg_read_addr   = {5'd0, rj};
            r.reg_write_valid = 1'b1;
            r.reg_write_addr  = rd;
            case (word[31:22])
                10'h00a: begin
                    r.aluop  = la_isa_pkg::ALU_ADD;
                    r.alusel = la_isa_pkg::RES_ARITH;
                end
                10'h008: begin
                    r.aluop  = la_isa_pkg::ALU_SLT;
                    r.alusel = la_isa_pkg::RES_ARITH;
                end
                10'h00d: begin
                    r.imm    = {20'h0, word[21:10]};
                    r.aluop  = la_isa_pkg::ALU_AND;
                    r.alusel = la_isa_pkg::RES_LOGIC;
                end
                10'h00e: begin
                    r.imm    = {20'h0, word[21:10]};
                    r.aluop  = la_isa_pkg::ALU_OR;
                    r.alusel = la_isa_pkg::RES_LOGIC;
                end
                10'h0a2: begin
                    r.aluop  = la_isa_pkg::ALU_LD_W;
                    r.alusel = la_isa_pkg::RES_LOAD_STORE;
                end
                10'h0a6: begin
                    r.reg_read_valid  = 2'b11;
                    r.reg_read_addr   = {rd, rj};
                    r.reg_write_valid = 1'b0;
                    r.reg_write_addr  = '0;
                    r.aluop           = la_isa_pkg::ALU_ST_W;
                    r.alusel          = la_isa_pkg::RES_LOAD_STORE;
                end
                default: begin
                    // unknown word, valid and illegal with nothing else
                    r         = '0;
                    r.valid   = 1'b1;
                    r.pc      = pc;
                    r.illegal = 1'b1;
                end
            endcase
        end
        return r;
    endfunction

    // valid slots land in program order from output slot 0
    function automatic expect_t expect_packet(input logic [`DECODE_WIDTH-1:0] valid,
        input logic [31:0] pc, input logic [`DECODE_WIDTH-1:0][31:0] instr);
        expect_t e;
        int      n;
        e = '0;
        n = 0;
        for (int k = 0; k < `DECODE_WIDTH; k++) begin
            if (valid[k]) begin
                e.res[n] = ref_decode(pc + 32'(4 * k), instr[k]);
                n++;
            end
        end
        e.count = `DEC_COUNT_WIDTH'(n);
        return e;
    endfunction

    task automatic compare_slot(input int k, input core_types_pkg::decode_result_t act,
                                input core_types_pkg::decode_result_t exp);
        string s;
        s = $sformatf("dec_result_o[%0d]", k);
        check_value({s, ".valid"}, act.valid, exp.valid);
        check_value({s, ".illegal"}, act.illegal, exp.illegal);
        check_value({s, ".pc"}, act.pc, exp.pc);
        check_value({s, ".reg_read_valid"}, act.reg_read_valid, exp.reg_read_valid);
        check_value({s, ".reg_read_addr"}, act.reg_read_addr, exp.reg_read_addr);
        check_value({s, ".use_imm"}, act.use_imm, exp.use_imm);
        check_value({s, ".imm"}, act.imm, exp.imm);
        check_value({s, ".reg_write_valid"}, act.reg_write_valid, exp.reg_write_valid);
        check_value({s, ".reg_write_addr"}, act.reg_write_addr, exp.reg_write_addr);
        check_value({s, ".aluop"}, act.aluop, exp.aluop);
        check_value({s, ".alusel"}, act.alusel, exp.alusel);
    endtask

    task automatic compare_packet(input expect_t e);
        check_value("dec_count_o", dec_count, e.count);
        for (int k = 0; k < `DECODE_WIDTH; k++) begin
            compare_slot(k, dec_result[k], e.res[k]);
        end
    endtask

    // outputs at this falling edge belong to the packet driven two edges back
    task automatic send_packet(input logic [`DECODE_WIDTH-1:0] valid, input logic [31:0] pc,
                               input logic [`DECODE_WIDTH-1:0][31:0] instr);
        @(negedge clk);
        if (exp_q.size() == 2) begin
            compare_packet(exp_q.pop_front());
        end
        fetch_valid = valid;
        fetch_pc    = pc;
        fetch_instr = instr;
        exp_q.push_back(expect_packet(valid, pc, instr));
    endtask

    task automatic send_pair(input logic [1:0] v, input logic [31:0] pc,
                             input logic [31:0] w0, input logic [31:0] w1);
        logic [`DECODE_WIDTH-1:0]           valid;
        logic [`DECODE_WIDTH-1:0][31:0]     instr;
        valid      = '0;
        instr      = '0;
        valid[1:0] = v;
        instr[0]   = w0;
        instr[1]   = w1;
        send_packet(valid, pc, instr);
    endtask

    task automatic flush_pipeline();
        repeat (2) send_packet('0, '0, '0);
    endtask

    task automatic check_outputs_empty();
        check_value("dec_count_o", dec_count, 0);
        for (int k = 0; k < `DECODE_WIDTH; k++) begin
            check_value($sformatf("dec_result_o[%0d].valid", k), dec_result[k].valid, 0);
        end
    endtask

    // strobes stay high through reset, so only the reset keeps the outputs empty
    task automatic test_reset_state();
        @(negedge clk);
        check_outputs_empty();
        arst_n      = 1'b1;
        fetch_valid = '0;
        @(negedge clk);
        check_outputs_empty();
    endtask

    task automatic test_2ri14();
        send_pair(2'b11, 32'h1c00_0000, enc_2ri14(8'h20, 14'h0123, 5'd3, 5'd4),
                  enc_2ri14(8'h21, 14'h3ff0, 5'd7, 5'd8));
        send_pair(2'b11, 32'h1c00_0010, enc_2ri14(8'h20, 14'h2000, 5'd31, 5'd1),
                  enc_2ri14(8'h21, 14'h1fff, 5'd0, 5'd30));
        flush_pipeline();
    endtask

    task automatic test_2ri12();
        send_pair(2'b11, 32'h1c00_0020, enc_2ri12(10'h00a, 12'h800, 5'd1, 5'd2),
                  enc_2ri12(10'h008, 12'h7ff, 5'd3, 5'd4));
        send_pair(2'b11, 32'h1c00_0030, enc_2ri12(10'h00d, 12'hf0f, 5'd5, 5'd6),
                  enc_2ri12(10'h00e, 12'h800, 5'd7, 5'd8));
        send_pair(2'b11, 32'h1c00_0040, enc_2ri12(10'h0a2, 12'hffc, 5'd9, 5'd10),
                  enc_2ri12(10'h0a6, 12'h010, 5'd11, 5'd12));
        flush_pipeline();
    endtask

    task automatic test_illegal();
        send_pair(2'b11, 32'h1c00_0050, 32'hffff_ffff, enc_2ri12(10'h00a, 12'h001, 5'd1, 5'd1));
        send_pair(2'b01, 32'h1c00_0060, 32'h0000_0000, 32'hffff_ffff);
        flush_pipeline();
    endtask

    // slot 1 alone must move down to output slot 0 with its own pc
    task automatic test_compaction();
        send_pair(2'b10, 32'h1c00_0100, enc_2ri14(8'h20, 14'h0004, 5'd2, 5'd3),
                  enc_2ri12(10'h00e, 12'h0ff, 5'd4, 5'd5));
        flush_pipeline();
    endtask

    task automatic test_random(input int n);
        logic [`DECODE_WIDTH-1:0]       valid;
        logic [31:0]                    pc;
        logic [`DECODE_WIDTH-1:0][31:0] instr;
        logic [31:0]                    word;
        int                             pick;
        for (int i = 0; i < n; i++) begin
            valid   = `DECODE_WIDTH'($random(seed));
            pc      = $random(seed);
            pc[1:0] = 2'b00;
            for (int k = 0; k < `DECODE_WIDTH; k++) begin
                word = $random(seed);
                pick = {$random(seed)} % 10;
                case (pick)
                    0: word[31:22] = 10'h008;
                    1: word[31:22] = 10'h00a;
                    2: word[31:22] = 10'h00d;
                    3: word[31:22] = 10'h00e;
                    4: word[31:22] = 10'h0a2;
                    5: word[31:22] = 10'h0a6;
                    6: word[31:24] = 8'h20;
                    7: word[31:24] = 8'h21;
                    // raw random word, mostly illegal
                    default: begin
                    end
                endcase
                instr[k] = word;
            end
            send_packet(valid, pc, instr);
        end
        flush_pipeline();
    endtask

    initial begin
        seed        = 32'heae0;
        arst_n      = 1'b0;
        fetch_valid = '1;
        fetch_pc    = '0;
        fetch_instr = '0;
        repeat (16) @(posedge clk);
        test_reset_state();
        test_2ri14();
        test_2ri12();
        test_illegal();
        test_compaction();
        test_random(RANDOM_PACKETS);
        if (dut0.u_collector.u_asserts.fail_count != 0) begin
            abort_run("Bound assertions on the collector outputs reported failures");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

//--- build.f
+incdir+design
design/la_isa_pkg.sv
design/core_types_pkg.sv
design/decoder_2ri14.sv
design/decoder_2ri12.sv
design/decode_lane.sv
design/instr_dispatcher.sv
design/decode_collector.sv
design/decode_stage.sv
sim/decode_asserts.sv
sim/tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - include_dirs:
      - design
    files:
      - design/la_isa_pkg.sv
      - design/core_types_pkg.sv
      - design/decoder_2ri14.sv
      - design/decoder_2ri12.sv
      - design/decode_lane.sv
      - design/instr_dispatcher.sv
      - design/decode_collector.sv
      - design/decode_stage.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/decode_asserts.sv
      - sim/tb_decode_stage.sv
